// ==== verilog/mem_pkg.sv ====
// Shared widths, memory command struct and peer identifiers for the memory subsystem
`default_nettype none

package mem_pkg;

    // Word address width of the shared memory, 4096 words
    localparam int MEM_AW = 12;

    // Memory word width
    localparam int MEM_DW = 16;

    // Byte address width of the download stream
    localparam int IOCTL_AW = MEM_AW + 1;

    // One memory command as seen by the arbiter and the controller
    typedef struct packed {
        // High for a write, low for a read
        logic              we;
        // Word address
        logic [MEM_AW-1:0] addr;
        // Write data, ignored on reads
        logic [MEM_DW-1:0] din;
        // Active-low byte enables, bit 0 is the low byte
        logic [1:0]        dsn;
    } mem_cmd_t;

    // Owner of a command, carried with reads so data returns to the right peer
    typedef enum logic [1:0] {
        PORT_PROG = 2'd0,
        PORT_CPU  = 2'd1,
        PORT_GFX  = 2'd2,
        PORT_NONE = 2'd3
    } port_id_t;

endpackage

`default_nettype wire

// ==== verilog/rom_loader.sv ====
// ROM loader that turns download byte writes into masked word write commands
`default_nettype none

module rom_loader
    import mem_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst,

    // Download stream
    input  wire logic                downloading,
    input  wire logic [IOCTL_AW-1:0] ioctl_addr,
    input  wire logic [7:0]          ioctl_dout,
    input  wire logic                ioctl_wr,

    // Arbiter side
    input  wire logic                ack,
    output logic                     req,
    output mem_cmd_t                 cmd,

    output logic                     dwnld_busy
);

    // A write command is pending until the arbiter takes it
    logic busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (ioctl_wr) begin
            busy <= 1'b1;
        end else if (ack) begin
            busy <= 1'b0;
        end
    end

    // Payload is captured with each byte and held until ack
    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            cmd.we   <= 1'b1;
            cmd.addr <= ioctl_addr[IOCTL_AW-1:1];
            // Same byte on both lanes, the mask picks the one written
            cmd.din  <= {2{ioctl_dout}};
            // Even byte address goes to the low lane
            cmd.dsn  <= ioctl_addr[0] ? 2'b01 : 2'b10;
        end
    end

    assign req        = busy;
    assign dwnld_busy = downloading | busy;

    // The download source must wait for dwnld_busy before the next byte
    a_no_wr_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        ioctl_wr |-> !busy
    );

endmodule

`default_nettype wire

// ==== verilog/rom_fetch.sv ====
// Game-side ROM read port with a one-word cache and request handshake
`default_nettype none

module rom_fetch
    import mem_pkg::*;
#(
    // Word offset of this port's region in the shared memory
    parameter int BASE = 0
) (
    input  wire logic              clk,
    input  wire logic              rst,

    // Game side
    input  wire logic              cs,
    input  wire logic [MEM_AW-2:0] addr,
    output logic      [MEM_DW-1:0] data,
    output logic                   ok,

    // Arbiter side
    output logic                   req,
    output mem_cmd_t               cmd,
    input  wire logic              ack,
    input  wire logic              dok,
    input  wire logic [MEM_DW-1:0] rdata
);

    logic              valid;
    logic [MEM_AW-2:0] cache_addr;
    logic [MEM_DW-1:0] cache_data;

    // Read accepted by the arbiter, data not yet back
    logic              pending;
    // Address of the read being requested or in flight
    logic [MEM_AW-2:0] req_addr;

    logic hit;
    logic miss;

    assign hit  = valid && (cache_addr == addr);
    assign miss = cs && !hit;

    assign ok   = cs && hit;
    assign data = cache_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            req     <= 1'b0;
            pending <= 1'b0;
            valid   <= 1'b0;
        end else begin
            if (req && ack) begin
                req     <= 1'b0;
                pending <= 1'b1;
            end else if (miss && !req && !pending) begin
                // Only one read at a time, a new miss waits for the old data
                req <= 1'b1;
            end
            if (dok) begin
                pending <= 1'b0;
                valid   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss && !req && !pending) begin
            req_addr <= addr;
        end
        if (dok) begin
            cache_addr <= req_addr;
            cache_data <= rdata;
        end
    end

    // Reads only, region base added here
    always_comb begin
        cmd.we   = 1'b0;
        cmd.addr = MEM_AW'(BASE) + {1'b0, req_addr};
        cmd.din  = '0;
        cmd.dsn  = 2'b11;
    end

    // Data-ok must belong to a read this port issued
    a_dok_outstanding: assert property (
        @(posedge clk) disable iff (rst)
        dok |-> pending
    );

endmodule

`default_nettype wire

// ==== verilog/mem_arbiter.sv ====
// Arbiter granting the loader and two fetch ports access to the memory controller
`default_nettype none

module mem_arbiter
    import mem_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,

    // ROM loader
    input  wire logic     prog_req,
    input  wire mem_cmd_t prog_cmd,
    input  wire logic     prog_busy,
    output logic          prog_ack,

    // CPU fetch port
    input  wire logic     cpu_req,
    input  wire mem_cmd_t cpu_cmd,
    output logic          cpu_ack,
    output logic          cpu_dok,

    // Graphics fetch port
    input  wire logic     gfx_req,
    input  wire mem_cmd_t gfx_cmd,
    output logic          gfx_ack,
    output logic          gfx_dok,

    // Controller
    output logic          cmd_valid,
    output mem_cmd_t      cmd,
    output port_id_t      tag,
    input  wire logic     cmd_ready,
    input  wire logic     rd_valid,
    input  wire port_id_t rd_tag
);

    // High when graphics won the last round-robin grant
    logic     last_gfx;
    port_id_t sel;
    logic     xfer;

    always_comb begin
        sel = PORT_NONE;
        if (prog_busy) begin
            // Download owns the memory
            if (prog_req) begin
                sel = PORT_PROG;
            end
        end else if (cpu_req && (!gfx_req || last_gfx)) begin
            sel = PORT_CPU;
        end else if (gfx_req) begin
            sel = PORT_GFX;
        end
    end

    always_comb begin
        case (sel)
            PORT_PROG: cmd = prog_cmd;
            PORT_CPU:  cmd = cpu_cmd;
            PORT_GFX:  cmd = gfx_cmd;
            default:   cmd = '0;
        endcase
    end

    assign cmd_valid = (sel != PORT_NONE);
    assign tag       = sel;
    assign xfer      = cmd_valid && cmd_ready;

    assign prog_ack = xfer && (sel == PORT_PROG);
    assign cpu_ack  = xfer && (sel == PORT_CPU);
    assign gfx_ack  = xfer && (sel == PORT_GFX);

    // Returned read data goes to whoever issued it
    assign cpu_dok = rd_valid && (rd_tag == PORT_CPU);
    assign gfx_dok = rd_valid && (rd_tag == PORT_GFX);

    always_ff @(posedge clk) begin
        if (rst) begin
            last_gfx <= 1'b0;
        end else if (cpu_ack || gfx_ack) begin
            last_gfx <= gfx_ack;
        end
    end

    // A loader write is only granted while busy holds off the fetch ports
    a_prog_req_busy: assert property (
        @(posedge clk) disable iff (rst)
        prog_req |-> prog_busy
    );

endmodule

`default_nettype wire

// ==== verilog/mem_ctrl.sv ====
// Memory controller model with word array, fixed read latency and refresh blocking
`default_nettype none

module mem_ctrl
    import mem_pkg::*;
#(
    // Cycles from read acceptance to data
    parameter int CAS_LAT  = 3,
    // Cycles with no new command after a refresh request
    parameter int RFSH_CYC = 4
) (
    input  wire logic              clk,
    input  wire logic              rst,

    input  wire logic              cmd_valid,
    input  wire mem_cmd_t          cmd,
    input  wire port_id_t          tag,
    output logic                   cmd_ready,

    input  wire logic              rfsh,

    output logic                   rd_valid,
    output port_id_t               rd_tag,
    output logic      [MEM_DW-1:0] rdata
);

    localparam int CW = $clog2(RFSH_CYC + 1);

    logic [MEM_DW-1:0] mem [2**MEM_AW];

    logic [CAS_LAT-1:0] vld_pipe;
    port_id_t           tag_pipe  [CAS_LAT];
    logic [MEM_DW-1:0]  data_pipe [CAS_LAT];

    logic          rfsh_l;
    logic          rfsh_rise;
    logic [CW-1:0] rfsh_cnt;

    logic accept;
    logic rd_acc;

    assign rfsh_rise = rfsh && !rfsh_l;

    // Blocked from the cycle of the rising edge on
    assign cmd_ready = (rfsh_cnt == '0) && !rfsh_rise;

    assign accept = cmd_valid && cmd_ready;
    assign rd_acc = accept && !cmd.we;

    always_ff @(posedge clk) begin
        if (rst) begin
            rfsh_l   <= 1'b0;
            rfsh_cnt <= '0;
        end else begin
            rfsh_l <= rfsh;
            if (rfsh_rise) begin
                rfsh_cnt <= CW'(RFSH_CYC - 1);
            end else if (rfsh_cnt != '0) begin
                rfsh_cnt <= rfsh_cnt - 1'b1;
            end
        end
    end

    // Valid bits of the read pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= rd_acc;
            for (int i = 1; i < CAS_LAT; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    // Array writes and the read data path
    always_ff @(posedge clk) begin
        if (accept && cmd.we) begin
            if (!cmd.dsn[0]) begin
                mem[cmd.addr][7:0] <= cmd.din[7:0];
            end
            if (!cmd.dsn[1]) begin
                mem[cmd.addr][15:8] <= cmd.din[15:8];
            end
        end
        data_pipe[0] <= mem[cmd.addr];
        tag_pipe[0]  <= tag;
        for (int i = 1; i < CAS_LAT; i++) begin
            data_pipe[i] <= data_pipe[i-1];
            tag_pipe[i]  <= tag_pipe[i-1];
        end
    end

    assign rd_valid = vld_pipe[CAS_LAT-1];
    assign rd_tag   = tag_pipe[CAS_LAT-1];
    assign rdata    = data_pipe[CAS_LAT-1];

    // Read data needs a fetch port to return to
    a_read_tag: assert property (
        @(posedge clk) disable iff (rst)
        rd_acc |-> (tag == PORT_CPU || tag == PORT_GFX)
    );

endmodule

`default_nettype wire

// ==== verilog/mem_subsys_top.sv ====
// Top level joining ROM loader, CPU and graphics fetch ports, arbiter and memory controller
`default_nettype none

module mem_subsys_top
    import mem_pkg::*;
#(
    parameter int CAS_LAT  = 3,
    parameter int RFSH_CYC = 4,
    parameter int CPU_BASE = 0,
    parameter int GFX_BASE = 2048
) (
    input  wire logic                clk,
    input  wire logic                rst,

    // ROM download
    input  wire logic                downloading,
    input  wire logic [IOCTL_AW-1:0] ioctl_addr,
    input  wire logic [7:0]          ioctl_dout,
    input  wire logic                ioctl_wr,
    output logic                     dwnld_busy,

    input  wire logic                rfsh,

    // CPU ROM port
    input  wire logic                cpu_cs,
    input  wire logic [MEM_AW-2:0]   cpu_addr,
    output logic      [MEM_DW-1:0]   cpu_data,
    output logic                     cpu_ok,

    // Graphics ROM port
    input  wire logic                gfx_cs,
    input  wire logic [MEM_AW-2:0]   gfx_addr,
    output logic      [MEM_DW-1:0]   gfx_data,
    output logic                     gfx_ok
);

    logic     prog_req, prog_ack;
    mem_cmd_t prog_cmd;
    logic     cpu_req, cpu_ack, cpu_dok;
    mem_cmd_t cpu_cmd;
    logic     gfx_req, gfx_ack, gfx_dok;
    mem_cmd_t gfx_cmd;

    logic              cmd_valid, cmd_ready, rd_valid;
    mem_cmd_t          cmd;
    port_id_t          tag, rd_tag;
    logic [MEM_DW-1:0] rdata;

    rom_loader u_loader (
        .clk(clk), .rst(rst), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr),
        .ack(prog_ack), .req(prog_req), .cmd(prog_cmd), .dwnld_busy(dwnld_busy)
    );

    // Both ports share the returned data bus
    rom_fetch #(.BASE(CPU_BASE)) u_cpu (
        .clk(clk), .rst(rst), .cs(cpu_cs), .addr(cpu_addr), .data(cpu_data), .ok(cpu_ok),
        .req(cpu_req), .cmd(cpu_cmd), .ack(cpu_ack), .dok(cpu_dok), .rdata(rdata)
    );

    rom_fetch #(.BASE(GFX_BASE)) u_gfx (
        .clk(clk), .rst(rst), .cs(gfx_cs), .addr(gfx_addr), .data(gfx_data), .ok(gfx_ok),
        .req(gfx_req), .cmd(gfx_cmd), .ack(gfx_ack), .dok(gfx_dok), .rdata(rdata)
    );

    mem_arbiter u_arb (
        .clk(clk), .rst(rst),
        .prog_req(prog_req), .prog_cmd(prog_cmd), .prog_busy(dwnld_busy),
        .prog_ack(prog_ack),
        .cpu_req(cpu_req), .cpu_cmd(cpu_cmd), .cpu_ack(cpu_ack), .cpu_dok(cpu_dok),
        .gfx_req(gfx_req), .gfx_cmd(gfx_cmd), .gfx_ack(gfx_ack), .gfx_dok(gfx_dok),
        .cmd_valid(cmd_valid), .cmd(cmd), .tag(tag), .cmd_ready(cmd_ready),
        .rd_valid(rd_valid), .rd_tag(rd_tag)
    );

    mem_ctrl #(.CAS_LAT(CAS_LAT), .RFSH_CYC(RFSH_CYC)) u_ctrl (
        .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd(cmd), .tag(tag),
        .cmd_ready(cmd_ready), .rfsh(rfsh),
        .rd_valid(rd_valid), .rd_tag(rd_tag), .rdata(rdata)
    );

endmodule

`default_nettype wire

// ==== dv/tb_mem_subsys.sv ====
// Testbench for mem_subsys_top with LFSR stimulus, memory model, checks and result reporting
`default_nettype none

module tb_mem_subsys
    import mem_pkg::*;
();

    localparam int CPU_BASE   = 0;
    localparam int GFX_BASE   = 2048;
    localparam int WAIT_LIMIT = 200;

    logic                clk;
    logic                rst;
    logic                downloading;
    logic [IOCTL_AW-1:0] ioctl_addr;
    logic [7:0]          ioctl_dout;
    logic                ioctl_wr;
    logic                dwnld_busy;
    logic                rfsh;
    logic                cpu_cs;
    logic [MEM_AW-2:0]   cpu_addr;
    logic [MEM_DW-1:0]   cpu_data;
    logic                cpu_ok;
    logic                gfx_cs;
    logic [MEM_AW-2:0]   gfx_addr;
    logic [MEM_DW-1:0]   gfx_data;
    logic                gfx_ok;

    // Reference copy of the shared memory
    logic [MEM_DW-1:0] model [2**MEM_AW];
    logic [31:0]       lfsr;
    logic              rfsh_on;
    int                errors;
    int                checks;
    int                test_errs;
    // Address each port was last pointed at
    logic [MEM_AW-2:0] last_cpu;
    logic [MEM_AW-2:0] last_gfx;

    mem_subsys_top #(
        .CAS_LAT(3), .RFSH_CYC(4), .CPU_BASE(CPU_BASE), .GFX_BASE(GFX_BASE)
    ) i_dut (
        .clk(clk), .rst(rst), .downloading(downloading), .ioctl_addr(ioctl_addr),
        .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr), .dwnld_busy(dwnld_busy), .rfsh(rfsh),
        .cpu_cs(cpu_cs), .cpu_addr(cpu_addr), .cpu_data(cpu_data), .cpu_ok(cpu_ok),
        .gfx_cs(gfx_cs), .gfx_addr(gfx_addr), .gfx_data(gfx_data), .gfx_ok(gfx_ok)
    );

    always #50 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic port_ok(bit gfx);
        return gfx ? gfx_ok : cpu_ok;
    endfunction

    function automatic logic [MEM_DW-1:0] port_data(bit gfx);
        return gfx ? gfx_data : cpu_data;
    endfunction

    // Model word of a port is its region base plus its address
    function automatic logic [MEM_AW-1:0] exp_word(bit gfx);
        if (gfx) begin
            return MEM_AW'(GFX_BASE) + {1'b0, gfx_addr};
        end
        return MEM_AW'(CPU_BASE) + {1'b0, cpu_addr};
    endfunction

    // Next falling edge with random refresh pulses when enabled
    task automatic tick();
        @(negedge clk);
        rfsh = rfsh_on && (take_bits(3) == 0);
    endtask

    task automatic check_word(bit gfx);
        logic [MEM_AW-1:0] w;
        w = exp_word(gfx);
        checks++;
        if (port_data(gfx) !== model[w]) begin
            $display("ERROR at time %0t: %s port word %h read %h, expected %h",
                     $time, gfx ? "gfx" : "cpu", w, port_data(gfx), model[w]);
            errors++;
        end
    endtask

    task automatic drive_port(bit gfx, logic [MEM_AW-2:0] a);
        if (gfx) begin
            gfx_cs   = 1'b1;
            gfx_addr = a;
            last_gfx = a;
        end else begin
            cpu_cs   = 1'b1;
            cpu_addr = a;
            last_cpu = a;
        end
    endtask

    task automatic write_byte(logic [IOCTL_AW-1:0] a, logic [7:0] b);
        int n;
        tick();
        ioctl_addr  = a;
        ioctl_dout  = b;
        ioctl_wr    = 1'b1;
        downloading = 1'b1;
        // Even byte address is the low lane
        if (a[0]) begin
            model[a[IOCTL_AW-1:1]][15:8] = b;
        end else begin
            model[a[IOCTL_AW-1:1]][7:0] = b;
        end
        tick();
        ioctl_wr    = 1'b0;
        downloading = 1'b0;
        #10;
        n = 0;
        while (dwnld_busy && n < WAIT_LIMIT) begin
            tick();
            #10;
            n++;
        end
        if (dwnld_busy) begin
            $display("Timeout: dwnld_busy stayed high after byte %h at time %0t", a, $time);
            errors++;
        end
    endtask

    task automatic wait_ok(bit gfx);
        int n;
        n = 0;
        while (!port_ok(gfx) && n < WAIT_LIMIT) begin
            tick();
            #10;
            n++;
        end
        if (!port_ok(gfx)) begin
            $display("Timeout: %s port never raised ok at time %0t", gfx ? "gfx" : "cpu", $time);
            errors++;
        end else begin
            check_word(gfx);
        end
    endtask

    task automatic read_one(bit gfx, logic [MEM_AW-2:0] a);
        tick();
        drive_port(gfx, a);
        #10;
        wait_ok(gfx);
    endtask

    // Both ports miss in the same cycle and each must finish in time
    task automatic read_pair(logic [MEM_AW-2:0] ca, logic [MEM_AW-2:0] ga);
        int n;
        bit c_done;
        bit g_done;
        tick();
        drive_port(1'b0, ca);
        drive_port(1'b1, ga);
        #10;
        c_done = 1'b0;
        g_done = 1'b0;
        n = 0;
        while (!(c_done && g_done) && n < WAIT_LIMIT) begin
            if (!c_done && cpu_ok) begin
                check_word(1'b0);
                c_done = 1'b1;
            end
            if (!g_done && gfx_ok) begin
                check_word(1'b1);
                g_done = 1'b1;
            end
            if (!(c_done && g_done)) begin
                tick();
                #10;
                n++;
            end
        end
        if (!c_done) begin
            $display("Timeout: cpu port starved during concurrent read at time %0t", $time);
            errors++;
        end
        if (!g_done) begin
            $display("Timeout: gfx port starved during concurrent read at time %0t", $time);
            errors++;
        end
    endtask

    task automatic end_test(int num, string name);
        $display("Test %0d %s finished with %0d errors", num, name, errors - test_errs);
        test_errs = errors;
    endtask

    initial begin
        logic [IOCTL_AW-1:0] ba;
        logic [MEM_AW-1:0]   w;
        logic [MEM_DW-1:0]   old;
        logic [MEM_DW-1:0]   got;
        logic [MEM_DW-1:0]   hold;
        logic [MEM_AW-2:0]   pa;
        logic [1:0]          sel;
        bit                  gfx_side;

        clk         = 1'b0;
        rst         = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        rfsh        = 1'b0;
        cpu_cs      = 1'b0;
        cpu_addr    = '0;
        gfx_cs      = 1'b0;
        gfx_addr    = '0;
        lfsr        = 32'h8f4d_008a;
        rfsh_on     = 1'b0;
        errors      = 0;
        checks      = 0;
        test_errs   = 0;
        last_cpu    = '1;
        last_gfx    = '1;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Ports selected straight away must still miss
        drive_port(1'b0, '0);
        drive_port(1'b1, '0);
        #10;

        checks++;
        if (dwnld_busy || cpu_ok || gfx_ok) begin
            $display("ERROR at time %0t: outputs not idle after reset", $time);
            errors++;
        end
        tick();
        cpu_cs = 1'b0;
        gfx_cs = 1'b0;
        end_test(1, "reset state");

        // Full image one byte at a time
        for (int i = 0; i < 2**IOCTL_AW; i++) begin
            write_byte(IOCTL_AW'(i), 8'(take_bits(8)));
        end
        // Move both caches off the words they fetched during the download
        read_one(1'b0, (MEM_AW-1)'(1));
        read_one(1'b1, (MEM_AW-1)'(1));
        for (int i = 0; i < 40; i++) begin
            read_one(1'b0, (MEM_AW-1)'(take_bits(MEM_AW-1)));
            read_one(1'b1, (MEM_AW-1)'(take_bits(MEM_AW-1)));
        end
        end_test(2, "download");

        for (int i = 0; i < 40; i++) begin
            ba = IOCTL_AW'(take_bits(IOCTL_AW));
            w  = ba[IOCTL_AW-1:1];
            old = model[w];
            // Upper half of memory is the graphics region
            gfx_side = w[MEM_AW-1];
            pa = w[MEM_AW-2:0];
            // Point the cache elsewhere so the readback is a real fetch
            if (gfx_side ? (last_gfx == pa) : (last_cpu == pa)) begin
                read_one(gfx_side, pa ^ 1'b1);
            end
            write_byte(ba, 8'(take_bits(8)));
            read_one(gfx_side, pa);
            got = port_data(gfx_side);
            checks++;
            if (ba[0] ? (got[7:0] !== old[7:0]) : (got[15:8] !== old[15:8])) begin
                $display("ERROR at time %0t: untouched lane of word %h changed, %h was %h",
                         $time, w, got, old);
                errors++;
            end
        end
        end_test(3, "byte lanes");

        for (int i = 0; i < 100; i++) begin
            read_pair((MEM_AW-1)'(take_bits(MEM_AW-1)), (MEM_AW-1)'(take_bits(MEM_AW-1)));
        end
        end_test(4, "concurrent reads");

        rfsh_on = 1'b1;
        for (int i = 0; i < 60; i++) begin
            sel = 2'(take_bits(2));
            if (sel == 2'd0) begin
                read_pair((MEM_AW-1)'(take_bits(MEM_AW-1)), (MEM_AW-1)'(take_bits(MEM_AW-1)));
            end else begin
                read_one(sel[0], (MEM_AW-1)'(take_bits(MEM_AW-1)));
            end
        end
        rfsh_on = 1'b0;
        tick();
        #10;
        end_test(5, "reads across refresh");

        for (int r = 0; r < 8; r++) begin
            gfx_side = r[0];
            pa = (MEM_AW-1)'(take_bits(MEM_AW-1));
            read_one(gfx_side, pa);
            hold = port_data(gfx_side);
            for (int k = 0; k < 5; k++) begin
                tick();
                #10;
                checks++;
                if (!port_ok(gfx_side) || port_data(gfx_side) !== hold) begin
                    $display("ERROR at time %0t: cache hit lost, ok %b data %h held %h",
                             $time, port_ok(gfx_side), port_data(gfx_side), hold);
                    errors++;
                end
            end
            tick();
            drive_port(gfx_side, pa + 1'b1);
            #10;
            checks++;
            if (port_ok(gfx_side)) begin
                $display("ERROR at time %0t: ok still high after address change", $time);
                errors++;
            end
            wait_ok(gfx_side);
        end
        end_test(6, "cache hits");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/mem_pkg.sv
verilog/rom_loader.sv
verilog/rom_fetch.sv
verilog/mem_arbiter.sv
verilog/mem_ctrl.sv
verilog/mem_subsys_top.sv
dv/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mem_subsys \
    -f build.f -Mdir obj_dir -o sim_mem_subsys

./obj_dir/sim_mem_subsys > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
